/* hdl/pkt_proxy_defines.svh */
`ifndef PKT_PROXY_DEFINES_SVH
`define PKT_PROXY_DEFINES_SVH

// ====================
// Datapath sizing
// ====================

// Data bits per packet beat
`define PKT_DATA_WID 32

// Words in each packet memory, one beat per word
`define PKT_MEM_DEPTH 64

// Address bits for one packet memory
`define PKT_ADDR_WID 6

// Beat FIFO entries, kept a power of two
`define PKT_FIFO_DEPTH 8

// Per-packet metadata bits
`define PKT_META_WID 6

`endif

/* hdl/pkt_proxy_pkg.sv */
`include "pkt_proxy_defines.svh"

package pkt_proxy_pkg;

    // ====================
    // Width types
    // ====================

    // One beat of packet data
    typedef logic [`PKT_DATA_WID-1:0] pkt_data_t;

    // Word address in a packet memory
    typedef logic [`PKT_ADDR_WID-1:0] pkt_addr_t;

    // Length in beats, 1 up to full memory depth
    typedef logic [`PKT_ADDR_WID:0] pkt_len_t;

    // Per-packet metadata
    typedef logic [`PKT_META_WID-1:0] pkt_meta_t;

    // ====================
    // Beat and FSM types
    // ====================

    // Entry carried through the beat FIFO
    typedef struct packed {
        pkt_data_t data;
        pkt_meta_t meta;
        logic      eop;
    } pkt_beat_t;

    // Playback sequencing
    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DRAIN,
        DONE
    } pb_state_e;

endpackage

/* hdl/pkt_beat_counter.sv */
`timescale 1ns/1ps

module pkt_beat_counter
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      step,
    input  pkt_len_t  last,
    output pkt_addr_t count,
    output logic      at_last
);

    // ====================
    // Address counter
    // ====================

    // Clear wins over step
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (step)
        begin
            // Wraps at full depth
            count <= count + pkt_addr_t'(1);
        end
    end

    // Terminal flag
    // Widened compare so a length of full depth still matches
    assign at_last = (pkt_len_t'(count) == (last - pkt_len_t'(1)));

endmodule

/* hdl/pkt_buffer_mem.sv */
`timescale 1ns/1ps

`include "pkt_proxy_defines.svh"

module pkt_buffer_mem
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  pkt_addr_t wr_addr,
    input  pkt_data_t wr_data,
    input  pkt_addr_t rd_addr,
    output pkt_data_t rd_data
);

    // ====================
    // Storage
    // ====================

    // One packet worth of words
    pkt_data_t mem [`PKT_MEM_DEPTH];

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ====================
    // Read port
    // ====================

    // Registered read, data one cycle after address
    // Read of a word written in the same cycle returns old contents
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/pkt_fifo.sv */
`timescale 1ns/1ps

`include "pkt_proxy_defines.svh"

module pkt_fifo
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  pkt_beat_t push_beat,
    input  logic      pop,
    output pkt_beat_t pop_beat,
    output logic      full,
    output logic      almost_full,
    output logic      empty
);

    localparam int DEPTH   = `PKT_FIFO_DEPTH;
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = PTR_WID + 1;

    // ====================
    // State
    // ====================

    pkt_beat_t            mem [DEPTH];
    logic [PTR_WID-1:0]   wr_ptr;
    logic [PTR_WID-1:0]   rd_ptr;
    logic [CNT_WID-1:0]   occ;
    logic                 push_ok;
    logic                 pop_ok;

    // Drop push on full, pop on empty
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Entry storage
    always_ff @(posedge clk)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= push_beat;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + PTR_WID'(1);
            if (pop_ok)
                rd_ptr <= rd_ptr + PTR_WID'(1);
            // Occupancy holds on simultaneous push and pop
            if (push_ok && !pop_ok)
                occ <= occ + CNT_WID'(1);
            else if (pop_ok && !push_ok)
                occ <= occ - CNT_WID'(1);
        end
    end

    // ====================
    // Outputs
    // ====================

    // Head entry, visible without a pop
    assign pop_beat = mem[rd_ptr];

    // Flags from occupancy
    assign full        = (occ == CNT_WID'(DEPTH));
    // At most one slot left, room for the read in flight
    assign almost_full = (occ >= CNT_WID'(DEPTH - 1));
    assign empty       = (occ == '0);

endmodule

/* hdl/pkt_playback_ctrl.sv */
`timescale 1ns/1ps

module pkt_playback_ctrl
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  pkt_len_t  pkt_len,
    input  pkt_meta_t pkt_meta,
    input  pkt_data_t rd_data,
    input  logic      almost_full,
    input  logic      at_last,
    output logic      cnt_clear,
    output logic      cnt_step,
    output logic      fifo_push,
    output pkt_beat_t push_beat,
    output pkt_len_t  last_len,
    output logic      busy
);

    pb_state_e state;
    pb_state_e state_nxt;
    logic      start_ok;
    logic      rd_valid;
    pkt_len_t  len_q;
    pkt_meta_t meta_q;

    // ====================
    // Control decode
    // ====================

    // Start only taken while not streaming
    assign start_ok  = start && ((state == IDLE) || (state == DONE));
    // Counter restarts at word 0 for every packet
    assign cnt_clear = start_ok;
    // One read per cycle unless the FIFO is nearly full
    assign cnt_step  = (state == STREAM) && !almost_full;
    // Low again once the eop beat is in the FIFO
    assign busy      = (state == STREAM) || (state == DRAIN);
    assign last_len  = len_q;

    // Next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
                if (start_ok)
                    state_nxt = STREAM;
            STREAM:
                // Last address read issued
                if (cnt_step && at_last)
                    state_nxt = DRAIN;
            DRAIN:
                state_nxt = DONE;
            DONE:
                state_nxt = start_ok ? STREAM : IDLE;
            default:
                state_nxt = IDLE;
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            rd_valid <= 1'b0;
            len_q    <= '0;
        end
        else
        begin
            state    <= state_nxt;
            // Read in flight, data lands next cycle
            rd_valid <= cnt_step;
            if (start_ok)
                len_q <= pkt_len;
        end
    end

    // Metadata rides with every beat
    always_ff @(posedge clk)
    begin
        if (start_ok)
            meta_q <= pkt_meta;
    end

    // Push one cycle behind the read
    assign fifo_push = rd_valid;
    // Final beat is the one pushed in DRAIN
    assign push_beat = '{data: rd_data, meta: meta_q, eop: (state == DRAIN)};

endmodule

/* hdl/pkt_capture_writer.sv */
`timescale 1ns/1ps

module pkt_capture_writer
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cap_hold,
    input  logic      empty,
    input  pkt_beat_t pop_beat,
    input  pkt_addr_t count,
    output logic      pop,
    output logic      cnt_clear,
    output logic      cnt_step,
    output logic      mem_wr_en,
    output pkt_addr_t mem_wr_addr,
    output pkt_data_t mem_wr_data,
    output pkt_len_t  cap_len,
    output pkt_meta_t cap_meta,
    output logic      pkt_done
);

    logic eop_pop;

    // ====================
    // Drain path
    // ====================

    // Pop whenever data waits and host is not holding
    assign pop     = !empty && !cap_hold;
    assign eop_pop = pop && pop_beat.eop;

    // Write the popped beat in the same cycle
    assign mem_wr_en   = pop;
    assign mem_wr_addr = count;
    assign mem_wr_data = pop_beat.data;

    // Next address, or back to 0 after the packet ends
    assign cnt_step  = pop && !pop_beat.eop;
    assign cnt_clear = eop_pop;

    // ====================
    // Packet summary
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cap_len  <= '0;
            cap_meta <= '0;
            pkt_done <= 1'b0;
        end
        else
        begin
            // Single-cycle pulse after the eop write
            pkt_done <= eop_pop;
            if (eop_pop)
            begin
                // Count is the eop address, length is one more
                cap_len  <= pkt_len_t'(count) + pkt_len_t'(1);
                cap_meta <= pop_beat.meta;
            end
        end
    end

endmodule

/* hdl/pkt_proxy_top.sv */
`timescale 1ns/1ps

`include "pkt_proxy_defines.svh"

module pkt_proxy_top
    import pkt_proxy_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pb_wr_en,
    input  pkt_addr_t pb_wr_addr,
    input  pkt_data_t pb_wr_data,
    input  logic      start,
    input  pkt_len_t  pkt_len,
    input  pkt_meta_t pkt_meta,
    input  logic      cap_hold,
    input  pkt_addr_t cap_rd_addr,
    output pkt_data_t cap_rd_data,
    output logic      busy,
    output logic      pkt_done,
    output pkt_len_t  cap_len,
    output pkt_meta_t cap_meta
);

    // Playback side
    pkt_addr_t pb_rd_addr;
    pkt_data_t pb_rd_data;
    pkt_len_t  pb_last_len;
    logic      pb_cnt_clear;
    logic      pb_cnt_step;
    logic      pb_at_last;

    // FIFO
    logic      fifo_push;
    logic      fifo_pop;
    logic      fifo_full;
    logic      fifo_almost_full;
    logic      fifo_empty;
    pkt_beat_t push_beat;
    pkt_beat_t pop_beat;

    // Capture side
    pkt_addr_t cap_count;
    logic      cap_cnt_clear;
    logic      cap_cnt_step;
    logic      cap_wr_en;
    pkt_addr_t cap_wr_addr;
    pkt_data_t cap_wr_data;

    // ====================
    // Playback path
    // ====================

    // Host loads, playback reads
    pkt_buffer_mem pb_mem_inst (
        .clk     (clk),
        .wr_en   (pb_wr_en),
        .wr_addr (pb_wr_addr),
        .wr_data (pb_wr_data),
        .rd_addr (pb_rd_addr),
        .rd_data (pb_rd_data)
    );

    pkt_beat_counter pb_cnt_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (pb_cnt_clear),
        .step    (pb_cnt_step),
        .last    (pb_last_len),
        .count   (pb_rd_addr),
        .at_last (pb_at_last)
    );

    pkt_playback_ctrl pb_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .pkt_len     (pkt_len),
        .pkt_meta    (pkt_meta),
        .rd_data     (pb_rd_data),
        .almost_full (fifo_almost_full),
        .at_last     (pb_at_last),
        .cnt_clear   (pb_cnt_clear),
        .cnt_step    (pb_cnt_step),
        .fifo_push   (fifo_push),
        .push_beat   (push_beat),
        .last_len    (pb_last_len),
        .busy        (busy)
    );

    // ====================
    // Beat FIFO
    // ====================

    pkt_fifo fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (fifo_push),
        .push_beat   (push_beat),
        .pop         (fifo_pop),
        .pop_beat    (pop_beat),
        .full        (fifo_full),
        .almost_full (fifo_almost_full),
        .empty       (fifo_empty)
    );

    // ====================
    // Capture path
    // ====================

    pkt_capture_writer cap_wr_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cap_hold    (cap_hold),
        .empty       (fifo_empty),
        .pop_beat    (pop_beat),
        .count       (cap_count),
        .pop         (fifo_pop),
        .cnt_clear   (cap_cnt_clear),
        .cnt_step    (cap_cnt_step),
        .mem_wr_en   (cap_wr_en),
        .mem_wr_addr (cap_wr_addr),
        .mem_wr_data (cap_wr_data),
        .cap_len     (cap_len),
        .cap_meta    (cap_meta),
        .pkt_done    (pkt_done)
    );

    // Full-depth span, eop decides where a packet ends
    pkt_beat_counter cap_cnt_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (cap_cnt_clear),
        .step    (cap_cnt_step),
        .last    (pkt_len_t'(`PKT_MEM_DEPTH)),
        .count   (cap_count),
        .at_last ()
    );

    // Capture writes, host reads back
    pkt_buffer_mem cap_mem_inst (
        .clk     (clk),
        .wr_en   (cap_wr_en),
        .wr_addr (cap_wr_addr),
        .wr_data (cap_wr_data),
        .rd_addr (cap_rd_addr),
        .rd_data (cap_rd_data)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int period_ns = 100
)
(
    output logic clk
);

    // Free-running clock, starts low
    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #(period_ns / 2);
        clk = ~clk;
    end

endmodule

/* dv/pkt_proxy_checker.sv */
`timescale 1ns/1ps

module pkt_proxy_checker
    import pkt_proxy_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      start,
    input logic      busy,
    input logic      pkt_done,
    input logic      fifo_push,
    input logic      fifo_pop,
    input logic      fifo_full,
    input pkt_beat_t push_beat
);

    // Count of failed properties, watched from the testbench top
    int unsigned fail_count = 0;

    // Beats in the FIFO, counted from its push and pop strobes
    int beats_held;
    // eop beats pushed and not yet closed by pkt_done
    int eop_pending;

    // ====================
    // Reference counts
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            beats_held  <= 0;
            eop_pending <= 0;
        end
        else
        begin
            beats_held  <= beats_held + int'(fifo_push) - int'(fifo_pop);
            eop_pending <= eop_pending + int'(fifo_push && push_beat.eop) - int'(pkt_done);
        end
    end

    // ====================
    // Host protocol
    // ====================

    // Start taken only while idle, busy follows one cycle later
    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
    else
    begin
        $error("busy did not rise in the cycle after an accepted start");
        fail_count++;
    end

    // Done is a one-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_done |=> !pkt_done)
    else
    begin
        $error("pkt_done stayed high for more than one cycle");
        fail_count++;
    end

    // Done only once an eop beat went through the FIFO
    done_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_done |-> (eop_pending > 0))
    else
    begin
        $error("pkt_done without an eop beat carried by the FIFO");
        fail_count++;
    end

    // ====================
    // FIFO safety
    // ====================

    no_push_on_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_push |-> !fifo_full)
    else
    begin
        $error("push into a full FIFO");
        fail_count++;
    end

    // Empty judged from the beats actually pushed
    no_pop_on_empty: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_pop |-> (beats_held > 0))
    else
    begin
        $error("pop from an empty FIFO");
        fail_count++;
    end

endmodule

/* dv/pkt_proxy_tb.sv */
`timescale 1ns/1ps

`include "pkt_proxy_defines.svh"

module pkt_proxy_tb
    import pkt_proxy_pkg::*;
();

    localparam int period_ns         = 100;
    localparam int drive_delay_ns    = 1;
    localparam int reset_cycles      = 10;
    // 1 + 2 + 1 + 4 + 1 packets over all tests
    localparam int packet_count      = 9;
    localparam int cycles_per_packet = 200;
    localparam int done_limit        = 300;
    localparam int watchdog_cycles   = packet_count * cycles_per_packet + reset_cycles;

    logic      clk;
    logic      rst_n;
    logic      pb_wr_en;
    pkt_addr_t pb_wr_addr;
    pkt_data_t pb_wr_data;
    logic      start;
    pkt_len_t  pkt_len;
    pkt_meta_t pkt_meta;
    logic      cap_hold;
    pkt_addr_t cap_rd_addr;
    pkt_data_t cap_rd_data;
    logic      busy;
    logic      pkt_done;
    pkt_len_t  cap_len;
    pkt_meta_t cap_meta;

    integer    seed = 32'h63e5;
    // Reference copy of the loaded packet
    pkt_data_t image [`PKT_MEM_DEPTH];

    // ====================
    // DUT and clock
    // ====================

    tb_clk_gen #(.period_ns(period_ns)) clk_gen_inst (.clk(clk));

    pkt_proxy_top pkt_proxy_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pb_wr_en    (pb_wr_en),
        .pb_wr_addr  (pb_wr_addr),
        .pb_wr_data  (pb_wr_data),
        .start       (start),
        .pkt_len     (pkt_len),
        .pkt_meta    (pkt_meta),
        .cap_hold    (cap_hold),
        .cap_rd_addr (cap_rd_addr),
        .cap_rd_data (cap_rd_data),
        .busy        (busy),
        .pkt_done    (pkt_done),
        .cap_len     (cap_len),
        .cap_meta    (cap_meta)
    );

    // Protocol checks see internal FIFO wires of the top
    bind pkt_proxy_top pkt_proxy_checker pkt_proxy_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .pkt_done   (pkt_done),
        .fifo_push  (fifo_push),
        .fifo_pop   (fifo_pop),
        .fifo_full  (fifo_full),
        .push_beat  (push_beat)
    );

    // ====================
    // Helpers
    // ====================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Next drive point, just after the rising edge
    task automatic tick();
        @(posedge clk);
        #(drive_delay_ns);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else
            abort_run($sformatf("mismatch at %0t: %s expected %0h actual %0h",
                                $time, name, expected, actual));
    endtask

    // Host writes a fresh random image into playback memory
    task automatic load_image(input pkt_len_t len);
        for (int i = 0; i < int'(len); i++)
        begin
            image[i]   = $random(seed);
            pb_wr_en   = 1'b1;
            pb_wr_addr = pkt_addr_t'(i);
            pb_wr_data = image[i];
            tick();
        end
        pb_wr_en = 1'b0;
    endtask

    task automatic start_packet(input pkt_len_t len, input pkt_meta_t meta);
        start    = 1'b1;
        pkt_len  = len;
        pkt_meta = meta;
        tick();
        start = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (pkt_done !== 1'b1)
        begin
            tick();
            cycles++;
            if (cycles > done_limit)
                abort_run("pkt_done did not arrive after a started packet");
        end
    endtask

    // Summary first, then word by word read-back
    task automatic check_capture(input pkt_len_t len, input pkt_meta_t meta);
        compare_value("cap_len", 32'(len), 32'(cap_len));
        compare_value("cap_meta", 32'(meta), 32'(cap_meta));
        for (int i = 0; i < int'(len); i++)
        begin
            cap_rd_addr = pkt_addr_t'(i);
            tick();
            compare_value($sformatf("cap_rd_data[%0d]", i), image[i], cap_rd_data);
        end
    endtask

    task automatic run_packet(input pkt_len_t len, input pkt_meta_t meta);
        load_image(len);
        start_packet(len, meta);
        wait_done();
        check_capture(len, meta);
    endtask

    function automatic pkt_len_t random_len();
        return pkt_len_t'(($unsigned($random(seed)) % `PKT_MEM_DEPTH) + 1);
    endfunction

    function automatic pkt_meta_t random_meta();
        return pkt_meta_t'($random(seed));
    endfunction

    // ====================
    // Watchdogs
    // ====================

    initial
    begin
        #(watchdog_cycles * period_ns);
        abort_run("watchdog expired before all tests finished");
    end

    // Checker failures end the run at once
    always @(negedge clk)
    begin
        if (pkt_proxy_top_inst.pkt_proxy_checker_inst.fail_count != 0)
            abort_run("a protocol assertion in the checker failed");
    end

    // ====================
    // Tests
    // ====================

    initial
    begin
        pkt_len_t  len;
        pkt_meta_t meta;
        int        full_seen;

        rst_n       = 1'b0;
        pb_wr_en    = 1'b0;
        pb_wr_addr  = '0;
        pb_wr_data  = '0;
        start       = 1'b0;
        pkt_len     = '0;
        pkt_meta    = '0;
        cap_hold    = 1'b0;
        cap_rd_addr = '0;
        repeat (reset_cycles) tick();
        rst_n = 1'b1;
        tick();

        // Idle outputs after reset
        compare_value("busy", 32'd0, 32'(busy));
        compare_value("pkt_done", 32'd0, 32'(pkt_done));
        compare_value("cap_len", 32'd0, 32'(cap_len));
        compare_value("cap_meta", 32'd0, 32'(cap_meta));

        // One random packet
        len  = random_len();
        meta = random_meta();
        run_packet(len, meta);

        // Length extremes
        run_packet(pkt_len_t'(1), random_meta());
        run_packet(pkt_len_t'(`PKT_MEM_DEPTH), random_meta());

        // Capture held while playback fills the FIFO
        len  = pkt_len_t'(40);
        meta = random_meta();
        load_image(len);
        cap_hold = 1'b1;
        start_packet(len, meta);
        full_seen = 0;
        repeat (30)
        begin
            if (pkt_proxy_top_inst.fifo_full)
            begin
                full_seen++;
                compare_value("busy", 32'd1, 32'(busy));
            end
            tick();
        end
        assert (full_seen > 0)
        else
            abort_run("FIFO never became full while cap_hold was high");
        cap_hold = 1'b0;
        wait_done();
        check_capture(len, meta);

        // Back to back packets
        repeat (4)
        begin
            len  = random_len();
            meta = random_meta();
            run_packet(len, meta);
        end

        // Second start during playback is dropped
        len  = pkt_len_t'(16 + ($unsigned($random(seed)) % 32));
        meta = random_meta();
        load_image(len);
        start_packet(len, meta);
        tick();
        compare_value("busy", 32'd1, 32'(busy));
        start_packet(len + pkt_len_t'(5), ~meta);
        wait_done();
        check_capture(len, meta);

        tick();
        if (pkt_proxy_top_inst.pkt_proxy_checker_inst.fail_count == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            abort_run("checker reported failures by the end of the run");
        end
    end

endmodule

/* pkt_proxy.f */
+incdir+hdl
hdl/pkt_proxy_pkg.sv
hdl/pkt_beat_counter.sv
hdl/pkt_buffer_mem.sv
hdl/pkt_fifo.sv
hdl/pkt_playback_ctrl.sv
hdl/pkt_capture_writer.sv
hdl/pkt_proxy_top.sv
dv/tb_clk_gen.sv
dv/pkt_proxy_checker.sv
dv/pkt_proxy_tb.sv

/* Bender.yml */
package:
  name: pkt_proxy

sources:
  # RTL
  - include_dirs:
      - hdl
    files:
      - hdl/pkt_proxy_pkg.sv
      - hdl/pkt_beat_counter.sv
      - hdl/pkt_buffer_mem.sv
      - hdl/pkt_fifo.sv
      - hdl/pkt_playback_ctrl.sv
      - hdl/pkt_capture_writer.sv
      - hdl/pkt_proxy_top.sv
  # Testbench
  - target: dv
    include_dirs:
      - hdl
    files:
      - dv/tb_clk_gen.sv
      - dv/pkt_proxy_checker.sv
      - dv/pkt_proxy_tb.sv
